// File: tb/div_testdata.txt
# columns: signed dividend divisor quotient remainder, all hex
# signed is 0 for unsigned and 1 for two's complement operands
0 00000064 00000007 0000000e 00000002
0 ffffffff 00000010 0fffffff 0000000f
0 12345678 00001000 00012345 00000678
0 00000005 0000000a 00000000 00000005
0 80000000 ffffffff 00000000 80000000
0 deadbeef 00000001 deadbeef 00000000
0 7fffffff 00000003 2aaaaaaa 00000001
0 ffffffff ffffffff 00000001 00000000
1 00000064 00000007 0000000e 00000002
1 ffffff9c 00000007 fffffff2 fffffffe
1 00000064 fffffff9 fffffff2 00000002
1 ffffff9c fffffff9 0000000e fffffffe
1 80000000 ffffffff 80000000 00000000
1 80000000 00000001 80000000 00000000
1 fffffff9 00000002 fffffffd ffffffff
1 7fffffff fffffffd d5555556 00000001
1 ffffffff ffffffff 00000001 00000000
0 12345678 00000000 ffffffff 12345678
1 fffffff9 00000000 ffffffff fffffff9
0 00000000 00000000 ffffffff 00000000

// File: div_apb_top.f
+incdir+hdl
hdl/div_pkg.sv
hdl/div_if.sv
hdl/div_reg_decode.sv
hdl/div_iter_core.sv
hdl/div_result_fix.sv
hdl/div_apb_top.sv
tb/div_apb_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the divider testbench with Verilator, pass only on the pass message

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing -f div_apb_top.f --top-module div_apb_tb -o div_apb_sim \
    > build.log 2>&1 \
    && ./obj_dir/div_apb_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^Test passed$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: tb/div_apb_tb.sv
`default_nettype none

`include "div_defines.svh"

module div_apb_tb;
    logic            clk;
    logic            reset;
    logic            psel;
    logic            penable;
    logic            pwrite;
    div_pkg::paddr_t paddr;
    div_pkg::word_t  pwdata;
    div_pkg::word_t  prdata;
    logic            pready;
    logic            pslverr;

    logic           vec_signed[$];
    div_pkg::word_t vec_dividend[$];
    div_pkg::word_t vec_divisor[$];
    div_pkg::word_t vec_quot[$];
    div_pkg::word_t vec_rem[$];

    int          value_errors;
    int          other_errors;
    logic [31:0] lfsr;
    logic        loaded;

    div_apb_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);  // One step per bit
        end
    endtask

    task automatic check_word(input string name, input div_pkg::word_t exp,
                              input div_pkg::word_t act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic pause_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // Setup then access, with the response sampled at the falling edge
    task automatic bus_write(input div_pkg::paddr_t addr, input div_pkg::word_t data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_flag("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic bus_read(input div_pkg::paddr_t addr, output div_pkg::word_t data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_flag("pready", 1'b1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] s;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] q;
        logic [31:0] r;
        fd = $fopen("tb/div_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test vector file tb/div_testdata.txt");
            other_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%h %h %h %h %h", s, a, b, q, r);
                if (n == 5) begin  // Comment and blank lines fall through
                    vec_signed.push_back(s[0]);
                    vec_dividend.push_back(a);
                    vec_divisor.push_back(b);
                    vec_quot.push_back(q);
                    vec_rem.push_back(r);
                end
            end
            $fclose(fd);
        end
        if (vec_quot.size() == 0) begin
            $display("No test vectors were read from the data file");
            other_errors++;
        end
    endtask

    task automatic wait_done();
        div_pkg::word_t st;
        logic           err;
        int             idle;
        st = '0;
        while (!st[`DIV_STAT_DONE]) begin
            draw_bits(3, idle);
            pause_cycles(idle);
            bus_read(`DIV_ADDR_STATUS, st, err);
            check_flag("pslverr", 1'b0, err);
        end
    endtask

    task automatic start_division(input int idx);
        div_pkg::word_t ctrl;
        logic           err;
        ctrl = '0;
        ctrl[`DIV_CTRL_START]  = 1'b1;
        ctrl[`DIV_CTRL_SIGNED] = vec_signed[idx];
        bus_write(`DIV_ADDR_DIVIDEND, vec_dividend[idx], err);
        check_flag("pslverr", 1'b0, err);
        bus_write(`DIV_ADDR_DIVISOR, vec_divisor[idx], err);
        check_flag("pslverr", 1'b0, err);
        bus_write(`DIV_ADDR_CTRL, ctrl, err);
        check_flag("pslverr", 1'b0, err);
    endtask

    task automatic run_division(input int idx);
        div_pkg::word_t st;
        div_pkg::word_t d;
        div_pkg::word_t q;
        div_pkg::word_t r;
        logic           err;
        start_division(idx);
        bus_read(`DIV_ADDR_STATUS, st, err);
        check_flag("status busy", 1'b1, st[`DIV_STAT_BUSY]);
        check_flag("status done", 1'b0, st[`DIV_STAT_DONE]);
        bus_write(`DIV_ADDR_DIVISOR, ~vec_divisor[idx], err);  // Locked while busy
        check_flag("pslverr", 1'b1, err);
        bus_read(`DIV_ADDR_DIVISOR, d, err);
        check_word("divisor", vec_divisor[idx], d);
        bus_write(`DIV_ADDR_CTRL, 32'h1, err);  // Second start refused
        check_flag("pslverr", 1'b1, err);
        wait_done();
        bus_read(`DIV_ADDR_QUOT, q, err);
        check_word("quot", vec_quot[idx], q);
        bus_read(`DIV_ADDR_REM, r, err);
        check_word("rem", vec_rem[idx], r);
    endtask

    task automatic abort_division(input int idx);
        div_pkg::word_t ctrl;
        div_pkg::word_t st;
        logic           err;
        start_division(idx);
        ctrl = '0;
        ctrl[`DIV_CTRL_ABORT] = 1'b1;
        bus_write(`DIV_ADDR_CTRL, ctrl, err);
        check_flag("pslverr", 1'b0, err);
        bus_read(`DIV_ADDR_STATUS, st, err);
        check_flag("status busy", 1'b0, st[`DIV_STAT_BUSY]);
        check_flag("status done", 1'b0, st[`DIV_STAT_DONE]);
        pause_cycles(`DIV_XLEN + 2);  // Beyond the normal latency
        bus_read(`DIV_ADDR_STATUS, st, err);
        check_flag("status busy", 1'b0, st[`DIV_STAT_BUSY]);
        check_flag("status done", 1'b0, st[`DIV_STAT_DONE]);
    endtask

    // Watchdog budget scales with the number of vectors
    initial begin
        wait (loaded);
        #((vec_quot.size() + 4) * (`DIV_XLEN + 30) * 10);
        $display("Timeout: the divider tests did not finish in the time allowed");
        $display("Test failed");
        $finish;
    end

    initial begin
        div_pkg::word_t rd;
        logic           err;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        reset        = 1'b1;
        value_errors = 0;
        other_errors = 0;
        lfsr         = 32'he1ff_2fa3;
        load_vectors();
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        bus_read(`DIV_ADDR_QUOT, rd, err);
        check_word("quot", '0, rd);
        bus_read(`DIV_ADDR_REM, rd, err);
        check_word("rem", '0, rd);
        bus_read(`DIV_ADDR_STATUS, rd, err);
        check_word("status", '0, rd);
        check_flag("pslverr", 1'b0, err);
        bus_read(8'h20, rd, err);  // Unmapped
        check_flag("pslverr", 1'b1, err);
        bus_write(`DIV_ADDR_STATUS, 32'h3, err);
        check_flag("pslverr", 1'b1, err);

        for (int i = 0; i < vec_quot.size(); i++) begin
            run_division(i);
        end
        if (vec_quot.size() > 0) begin
            abort_division(0);
            run_division(0);
        end

        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/div_apb_top.sv
`default_nettype none

module div_apb_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  div_pkg::paddr_t  paddr,
    input  div_pkg::word_t   pwdata,
    output div_pkg::word_t   prdata,
    output logic             pready,
    output logic             pslverr
);
    div_req_if req_if ();
    div_raw_if raw_if ();

    div_pkg::word_t quot;
    div_pkg::word_t rem;
    logic           done;

    div_reg_decode decode_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req_if.decode),
        .quot    (quot),
        .rem     (rem),
        .done    (done)
    );

    div_iter_core core_i (
        .clk   (clk),
        .reset (reset),
        .req   (req_if.exec),
        .raw   (raw_if.exec)
    );

    div_result_fix result_i (
        .clk   (clk),
        .reset (reset),
        .raw   (raw_if.result),
        .quot  (quot),
        .rem   (rem),
        .done  (done)
    );

endmodule

`default_nettype wire

// File: hdl/div_result_fix.sv
`default_nettype none

module div_result_fix (
    input  logic            clk,
    input  logic            reset,
    div_raw_if.result       raw,
    output div_pkg::word_t  quot,
    output div_pkg::word_t  rem,
    output logic            done
);
    div_pkg::word_t quot_fix;
    div_pkg::word_t rem_fix;

    // Divide by zero overrides the sign correction
    always_comb begin
        if (raw.div_zero) begin
            quot_fix = '1;
            rem_fix  = raw.raw_rem;  // Carries the original dividend
        end else begin
            quot_fix = raw.neg_quot ? -raw.raw_quot : raw.raw_quot;
            rem_fix  = raw.neg_rem ? -raw.raw_rem : raw.raw_rem;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            quot <= '0;
            rem  <= '0;
        end else if (raw.fin) begin
            quot <= quot_fix;
            rem  <= rem_fix;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (raw.start_seen) begin
            done <= 1'b0;  // New division wins over a finishing one
        end else if (raw.fin) begin
            done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/div_iter_core.sv
`default_nettype none

`include "div_defines.svh"

module div_iter_core (
    input  logic      clk,
    input  logic      reset,
    div_req_if.exec   req,
    div_raw_if.exec   raw
);
    localparam int xlen = `DIV_XLEN;

    div_pkg::exec_state_t state;
    div_pkg::cnt_t        cnt;

    logic [2*xlen-1:0] part_rem;    // Remainder window above the unused dividend bits
    div_pkg::word_t    div_abs;
    div_pkg::word_t    quot_acc;
    div_pkg::word_t    dividend_orig;
    logic              neg_quot_q;
    logic              neg_rem_q;
    logic              div_zero_q;

    logic           accept;
    logic           last_step;
    logic           dividend_neg;
    logic           divisor_neg;
    div_pkg::word_t dividend_abs;
    div_pkg::word_t divisor_abs;
    logic [xlen:0]  trial;
    logic           borrow;

    assign accept    = req.start && !req.busy && !req.abort;
    assign last_step = (cnt == div_pkg::cnt_t'(xlen - 1));

    assign dividend_neg = req.signed_op && req.dividend[xlen-1];
    assign divisor_neg  = req.signed_op && req.divisor[xlen-1];
    assign dividend_abs = dividend_neg ? -req.dividend : req.dividend;
    assign divisor_abs  = divisor_neg ? -req.divisor : req.divisor;

    // Top bit of the trial subtract is the borrow
    assign trial  = part_rem[2*xlen-1:xlen-1] + {1'b1, ~div_abs} + {{xlen{1'b0}}, 1'b1};
    assign borrow = trial[xlen];

    always_ff @(posedge clk) begin
        if (reset || req.abort) begin
            state <= div_pkg::idle;
        end else begin
            case (state)
                div_pkg::idle: begin
                    if (accept) begin
                        state <= div_pkg::run;
                    end
                end
                div_pkg::run: begin
                    if (last_step) begin
                        state <= div_pkg::finish;
                    end
                end
                div_pkg::finish: begin
                    state <= accept ? div_pkg::run : div_pkg::idle;  // Back-to-back start
                end
                default: begin
                    state <= div_pkg::idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset || accept) begin
            cnt <= '0;
        end else if (state == div_pkg::run) begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            part_rem      <= {{xlen{1'b0}}, dividend_abs};
            div_abs       <= divisor_abs;
            dividend_orig <= req.dividend;
            neg_quot_q    <= dividend_neg ^ divisor_neg;
            neg_rem_q     <= dividend_neg;
            div_zero_q    <= (req.divisor == '0);
        end else if (state == div_pkg::run) begin
            if (borrow) begin
                part_rem <= {part_rem[2*xlen-2:0], 1'b0};
            end else begin
                part_rem <= {trial[xlen-1:0], part_rem[xlen-2:0], 1'b0};
            end
            quot_acc <= {quot_acc[xlen-2:0], ~borrow};
        end
    end

    assign req.busy = (state == div_pkg::run);

    assign raw.fin        = (state == div_pkg::finish) && !req.abort;
    assign raw.start_seen = accept;
    assign raw.raw_quot   = quot_acc;
    assign raw.raw_rem    = div_zero_q ? dividend_orig : part_rem[2*xlen-1:xlen];
    assign raw.neg_quot   = neg_quot_q;
    assign raw.neg_rem    = neg_rem_q;
    assign raw.div_zero   = div_zero_q;

endmodule

`default_nettype wire

// File: hdl/div_reg_decode.sv
`default_nettype none

`include "div_defines.svh"

module div_reg_decode (
    input  logic             clk,
    input  logic             reset,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  div_pkg::paddr_t  paddr,
    input  div_pkg::word_t   pwdata,
    output div_pkg::word_t   prdata,
    output logic             pready,
    output logic             pslverr,
    div_req_if.decode        req,
    input  div_pkg::word_t   quot,
    input  div_pkg::word_t   rem,
    input  logic             done
);
    div_pkg::word_t dividend_q;
    div_pkg::word_t divisor_q;
    div_pkg::word_t rdata;

    logic access;
    logic addr_ok;
    logic wr_err;
    logic err;
    logic wr_ok;
    logic ctrl_wr;

    assign access = psel && penable;  // Access phase completes at once

    // Address decode and write protection
    always_comb begin
        addr_ok = 1'b1;
        wr_err  = 1'b0;
        case (paddr)
            `DIV_ADDR_DIVIDEND,
            `DIV_ADDR_DIVISOR: begin
                wr_err = req.busy;  // Operands locked during a division
            end
            `DIV_ADDR_CTRL: begin
                wr_err = req.busy && pwdata[`DIV_CTRL_START];
            end
            `DIV_ADDR_STATUS,
            `DIV_ADDR_QUOT,
            `DIV_ADDR_REM: begin
                wr_err = 1'b1;  // Read-only
            end
            default: begin
                addr_ok = 1'b0;
            end
        endcase
    end

    assign err     = !addr_ok || (pwrite && wr_err);
    assign pslverr = access && err;
    assign pready  = 1'b1;
    assign wr_ok   = access && pwrite && !err;
    assign ctrl_wr = wr_ok && (paddr == `DIV_ADDR_CTRL);

    always_ff @(posedge clk) begin
        if (reset) begin
            dividend_q <= '0;
            divisor_q  <= '0;
        end else begin
            if (wr_ok && (paddr == `DIV_ADDR_DIVIDEND)) begin
                dividend_q <= pwdata;
            end
            if (wr_ok && (paddr == `DIV_ADDR_DIVISOR)) begin
                divisor_q <= pwdata;
            end
        end
    end

    // CTRL bits act as pulses in the access cycle
    assign req.start     = ctrl_wr && pwdata[`DIV_CTRL_START];
    assign req.abort     = ctrl_wr && pwdata[`DIV_CTRL_ABORT];
    assign req.signed_op = pwdata[`DIV_CTRL_SIGNED];
    assign req.dividend  = dividend_q;
    assign req.divisor   = divisor_q;

    // Read mux
    always_comb begin
        rdata = '0;
        case (paddr)
            `DIV_ADDR_DIVIDEND: begin
                rdata = dividend_q;
            end
            `DIV_ADDR_DIVISOR: begin
                rdata = divisor_q;
            end
            `DIV_ADDR_STATUS: begin
                rdata[`DIV_STAT_BUSY] = req.busy;
                rdata[`DIV_STAT_DONE] = done;
            end
            `DIV_ADDR_QUOT: begin
                rdata = quot;
            end
            `DIV_ADDR_REM: begin
                rdata = rem;
            end
            default: begin
                rdata = '0;  // CTRL reads back as zero
            end
        endcase
    end

    assign prdata = (access && !pwrite) ? rdata : '0;

endmodule

`default_nettype wire

// File: hdl/div_if.sv
`default_nettype none

// Request path from register decode to the execute core
interface div_req_if;
    logic start;                 // One-cycle pulse
    logic signed_op;
    div_pkg::word_t dividend;
    div_pkg::word_t divisor;
    logic abort;                 // One-cycle pulse
    logic busy;

    modport decode (
        output start,
        output signed_op,
        output dividend,
        output divisor,
        output abort,
        input  busy
    );

    modport exec (
        input  start,
        input  signed_op,
        input  dividend,
        input  divisor,
        input  abort,
        output busy
    );
endinterface

// Unsigned results and correction flags from execute to the result stage
interface div_raw_if;
    logic fin;                   // One-cycle pulse
    div_pkg::word_t raw_quot;
    div_pkg::word_t raw_rem;
    logic neg_quot;
    logic neg_rem;
    logic div_zero;
    logic start_seen;            // New division accepted

    modport exec (
        output fin,
        output raw_quot,
        output raw_rem,
        output neg_quot,
        output neg_rem,
        output div_zero,
        output start_seen
    );

    modport result (
        input fin,
        input raw_quot,
        input raw_rem,
        input neg_quot,
        input neg_rem,
        input div_zero,
        input start_seen
    );
endinterface

`default_nettype wire

// File: hdl/div_pkg.sv
`default_nettype none

`include "div_defines.svh"

package div_pkg;

    // Operand, quotient and remainder
    typedef logic [`DIV_XLEN-1:0] word_t;

    // Iteration count of the shift-subtract loop
    typedef logic [`DIV_CNT_W-1:0] cnt_t;

    typedef logic [7:0] paddr_t;  // APB byte address

    // Execute core states
    typedef enum logic [1:0] {
        idle,
        run,
        finish
    } exec_state_t;

endpackage

`default_nettype wire

// File: hdl/div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// Operand and counter widths
`define DIV_XLEN 32
`define DIV_CNT_W 6

// APB register map
`define DIV_ADDR_DIVIDEND 8'h00
`define DIV_ADDR_DIVISOR 8'h04
`define DIV_ADDR_CTRL 8'h08
`define DIV_ADDR_STATUS 8'h0C
`define DIV_ADDR_QUOT 8'h10
`define DIV_ADDR_REM 8'h14

`define DIV_CTRL_START 0
`define DIV_CTRL_SIGNED 1
`define DIV_CTRL_ABORT 2
`define DIV_STAT_BUSY 0
`define DIV_STAT_DONE 1

`endif
